// File: include/gb_bus_consts.svh
`ifndef GB_BUS_CONSTS_SVH
`define GB_BUS_CONSTS_SVH

// Memory region bounds.
`define GB_BOOT_END      16'h00ff
`define GB_ROM_END       16'h7fff
`define GB_VRAM_END      16'h9fff
`define GB_XRAM_END      16'hbfff
`define GB_WRAM_END      16'hdfff
`define GB_OAM_BASE      16'hfe00
`define GB_OAM_END       16'hfe9f
`define GB_IO_PAGE       16'hff00

// Register offsets inside the I/O page.
`define GB_IO_JOY        8'h00
`define GB_IO_SIO_LO     8'h01
`define GB_IO_SIO_HI     8'h02
`define GB_IO_TIM_LO     8'h04
`define GB_IO_TIM_HI     8'h07
`define GB_IO_IF         8'h0f
`define GB_IO_SND_LO     8'h10
`define GB_IO_SND_HI     8'h3f
`define GB_IO_PPU_LO     8'h40
`define GB_IO_PPU_HI     8'h4b
`define GB_IO_BROM       8'h50
`define GB_IO_HRAM_LO    8'h80
`define GB_IO_IE         8'hff

// Reset phase counter width.
`define GB_RST_TICK_BITS 4

`endif

// File: hdl/gb_bus_pkg.sv
package gb_bus_pkg;

	// CPU address, flat or as I/O page plus register offset.
	typedef union packed {
		logic [15:0] mem;
		struct packed {
			logic [7:0] page;
			logic [7:0] reg_ofs;
		} io;
	} cpu_adr_u;

	typedef struct packed {
		cpu_adr_u   adr;
		logic       rd;
		logic       wr;
		logic [7:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic brom;
		logic rom;
		logic vram;
		logic xram;
		logic wram;
		logic oam;
		logic io;
	} mem_sel_t;

	typedef struct packed {
		logic joy;
		logic sio;
		logic tim;
		logic iflag;
		logic snd;
		logic ppu;
		logic brom;
		logic hram;
		logic iena;
	} io_sel_t;

	typedef struct packed {
		logic        active;
		logic [15:0] rd_adr;
		logic [7:0]  oam_adr;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
	} dma_req_t;

	typedef struct packed {
		logic [15:0] adr;
		logic        rd;
		logic        need_vram;
		logic        need_oam;
	} ppu_req_t;

	// One port toward video RAM or OAM.
	typedef struct packed {
		logic [15:0] adr;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
	} mem_port_t;

	typedef struct packed {
		logic [7:0] hram;
		logic [7:0] joy;
		logic [7:0] sio;
		logic [7:0] tim;
		logic [7:0] snd;
		logic [7:0] ppu;
		logic [7:0] ireg;
		logic [7:0] vram;
		logic [7:0] oam;
		logic [7:0] ext;
	} periph_rdata_t;

	typedef struct packed {
		logic [15:0] adr;
		logic        n_read;
		logic        n_write;
		logic        data_oe;
		logic [7:0]  data_out;
		logic        n_cs_rom;
		logic        n_cs_xram;
		logic        n_cs_wram;
	} ext_pins_t;

endpackage

// File: hdl/gb_memmap.sv
`timescale 1ns/1ps
`include "gb_bus_consts.svh"

module gb_memmap (
	input  logic [15:0]          adr,
	input  logic                 boot_en,
	input  logic                 idle,
	output gb_bus_pkg::mem_sel_t sel
);

	always_comb begin
		sel = '0;

		if (!idle) begin
			// Boot ROM overlays the bottom of cartridge ROM.
			if (boot_en && adr <= `GB_BOOT_END) begin
				sel.brom = 1'b1;
			end else if (adr <= `GB_ROM_END) begin
				sel.rom = 1'b1;
			end else if (adr <= `GB_VRAM_END) begin
				sel.vram = 1'b1;
			end else if (adr <= `GB_XRAM_END) begin
				sel.xram = 1'b1;
			end else if (adr <= `GB_WRAM_END) begin
				sel.wram = 1'b1;
			end else if (adr < `GB_OAM_BASE) begin
				// Echo area.
				sel.wram = 1'b1;
			end else if (adr <= `GB_OAM_END) begin
				sel.oam = 1'b1;
			end else if (adr >= `GB_IO_PAGE) begin
				sel.io = 1'b1;
			end
			// Gap above OAM selects nothing.
		end
	end

endmodule

// File: hdl/gb_io_decode.sv
`timescale 1ns/1ps
`include "gb_bus_consts.svh"

module gb_io_decode (
	input  logic                 gbclk,
	input  logic                 reset,
	input  logic                 bus_reset,
	input  gb_bus_pkg::cpu_adr_u cpu_adr,
	input  logic                 io_page,
	input  logic                 wr,
	input  logic [7:0]           wdata,
	output gb_bus_pkg::io_sel_t  sel,
	output logic                 boot_hidden
);

	logic [7:0] ofs;

	assign ofs = cpu_adr.io.reg_ofs;

	always_comb begin
		sel = '0;

		if (io_page) begin
			sel.joy   = ofs == `GB_IO_JOY;
			sel.sio   = ofs >= `GB_IO_SIO_LO && ofs <= `GB_IO_SIO_HI;
			sel.tim   = ofs >= `GB_IO_TIM_LO && ofs <= `GB_IO_TIM_HI;
			sel.iflag = ofs == `GB_IO_IF;
			sel.snd   = ofs >= `GB_IO_SND_LO && ofs <= `GB_IO_SND_HI;
			sel.ppu   = ofs >= `GB_IO_PPU_LO && ofs <= `GB_IO_PPU_HI;
			sel.brom  = ofs == `GB_IO_BROM;
			sel.hram  = ofs >= `GB_IO_HRAM_LO && ofs != `GB_IO_IE;
			sel.iena  = ofs == `GB_IO_IE;
		end
	end

	// Once hidden, the boot ROM stays hidden until the next bus reset.
	always_ff @(posedge gbclk) begin
		if (reset || bus_reset) begin
			boot_hidden <= 1'b0;
		end else if (wr && sel.brom && wdata != 8'h00) begin
			boot_hidden <= 1'b1;
		end
	end

endmodule

// File: hdl/gb_reset_seq.sv
`timescale 1ns/1ps
`include "gb_bus_consts.svh"

module gb_reset_seq (
	input  logic gbclk,
	input  logic reset,
	input  logic gb_on,
	input  logic cart_rst_n,
	output logic reset_done,
	output logic bus_reset,
	output logic cart_rst_drive_n
);

	localparam logic [2:0] S_ASSERT  = 3'b001;
	localparam logic [2:0] S_RELEASE = 3'b010;
	localparam logic [2:0] S_DONE    = 3'b100;

	logic [2:0]                   state;
	logic [`GB_RST_TICK_BITS-1:0] init_ticks;
	logic [`GB_RST_TICK_BITS-1:0] ticks;
	logic                         init_done;
	logic                         gb_on_q;
	logic                         restart;

	// Power level change, or the cartridge pulling reset once running.
	assign restart = (gb_on != gb_on_q) || (state == S_DONE && !cart_rst_n);

	always_ff @(posedge gbclk) begin
		if (reset) begin
			init_ticks <= '0;
			init_done  <= 1'b0;
			gb_on_q    <= 1'b0;
			state      <= S_ASSERT;
			ticks      <= '0;
		end else begin
			gb_on_q <= gb_on;

			if (!init_done) begin
				init_ticks <= init_ticks + 1'b1;
			end
			if (&init_ticks) begin
				init_done <= 1'b1;
			end

			if (restart) begin
				state <= S_ASSERT;
				ticks <= '0;
			end else if (init_done) begin
				case (state)
					S_ASSERT: begin
						if (&ticks) begin
							state <= S_RELEASE;
							ticks <= '0;
						end else begin
							ticks <= ticks + 1'b1;
						end
					end
					S_RELEASE: begin
						// Cartridge still holding reset.
						if (!cart_rst_n) begin
							ticks <= '0;
						end else if (&ticks) begin
							state <= S_DONE;
						end else begin
							ticks <= ticks + 1'b1;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign reset_done       = state == S_DONE;
	assign bus_reset        = !(reset_done && gb_on);
	assign cart_rst_drive_n = !(init_done && state == S_ASSERT && gb_on);

endmodule

// File: hdl/gb_bus_arbiter.sv
`timescale 1ns/1ps
`include "gb_bus_consts.svh"

module gb_bus_arbiter (
	input  gb_bus_pkg::bus_req_t  cpu_req,
	input  gb_bus_pkg::dma_req_t  dma_req,
	input  gb_bus_pkg::ppu_req_t  ppu_req,
	input  gb_bus_pkg::mem_sel_t  cpu_sel,
	input  gb_bus_pkg::mem_sel_t  dma_sel,
	input  gb_bus_pkg::mem_sel_t  ppu_sel,
	output gb_bus_pkg::mem_port_t vram_port,
	output gb_bus_pkg::mem_port_t oam_port,
	output gb_bus_pkg::bus_req_t  ext_req,
	output logic                  cs_rom,
	output logic                  cs_xram,
	output logic                  cs_wram,
	output logic                  cpu_grant_vram,
	output logic                  cpu_grant_oam,
	output logic                  cpu_grant_ext,
	output logic                  dma_grant_vram,
	output logic                  dma_grant_ext
);

	logic cpu_ext;
	logic dma_ext;

	assign cpu_ext = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_ext = dma_sel.rom || dma_sel.xram || dma_sel.wram;

	assign dma_grant_vram = dma_req.active && dma_sel.vram && !ppu_req.need_vram;
	assign cpu_grant_vram = cpu_sel.vram && !ppu_req.need_vram && !dma_grant_vram;
	assign cpu_grant_oam  = cpu_sel.oam && !ppu_req.need_oam && !dma_req.active;
	assign dma_grant_ext  = dma_req.active && dma_ext;
	assign cpu_grant_ext  = cpu_ext && !dma_grant_ext;

	// Video RAM. Picture unit and DMA only ever read.
	always_comb begin
		vram_port = '0;

		if (ppu_req.need_vram) begin
			vram_port.adr = ppu_req.adr;
			vram_port.rd  = ppu_req.rd && ppu_sel.vram;
		end else if (dma_grant_vram) begin
			vram_port.adr = dma_req.rd_adr;
			vram_port.rd  = dma_req.rd;
		end else if (cpu_grant_vram) begin
			vram_port.adr   = cpu_req.adr.mem;
			vram_port.rd    = cpu_req.rd;
			vram_port.wr    = cpu_req.wr;
			vram_port.wdata = cpu_req.wdata;
		end
	end

	// OAM. An active DMA owns it as a writer.
	always_comb begin
		oam_port = '0;

		if (ppu_req.need_oam) begin
			oam_port.adr = ppu_req.adr;
			oam_port.rd  = ppu_req.rd && ppu_sel.oam;
		end else if (dma_req.active) begin
			oam_port.adr   = `GB_OAM_BASE | {8'h00, dma_req.oam_adr};
			oam_port.wr    = dma_req.wr;
			oam_port.wdata = dma_req.wdata;
		end else if (cpu_grant_oam) begin
			oam_port.adr   = cpu_req.adr.mem;
			oam_port.rd    = cpu_req.rd;
			oam_port.wr    = cpu_req.wr;
			oam_port.wdata = cpu_req.wdata;
		end
	end

	// External bus follows the CPU unless the DMA reads from it.
	always_comb begin
		ext_req = cpu_req;

		if (dma_grant_ext) begin
			ext_req.adr.mem = dma_req.rd_adr;
			ext_req.rd      = dma_req.rd;
			ext_req.wr      = 1'b0;
		end
	end

	assign cs_rom  = cpu_sel.rom || dma_sel.rom;
	assign cs_xram = cpu_sel.xram || dma_sel.xram;
	assign cs_wram = cpu_sel.wram || dma_sel.wram;

endmodule

// File: hdl/gb_read_mux.sv
`timescale 1ns/1ps

module gb_read_mux (
	input  gb_bus_pkg::io_sel_t       io_sel,
	input  gb_bus_pkg::mem_sel_t      cpu_sel,
	input  gb_bus_pkg::cpu_adr_u      cpu_adr,
	input  logic [4:0]                grants,
	input  gb_bus_pkg::periph_rdata_t rdata,
	output logic [7:0]                cpu_rdata,
	output logic [7:0]                dma_rdata
);

	logic cpu_grant_vram;
	logic cpu_grant_oam;
	logic cpu_grant_ext;
	logic dma_grant_vram;
	logic dma_grant_ext;

	// Grant order from the arbiter, MSB first.
	assign {cpu_grant_vram, cpu_grant_oam, cpu_grant_ext,
		dma_grant_vram, dma_grant_ext} = grants;

	always_comb begin
		cpu_rdata = 8'hff;

		if (io_sel.hram) begin
			cpu_rdata = rdata.hram;
		end else if (io_sel.joy) begin
			cpu_rdata = rdata.joy;
		end else if (io_sel.sio) begin
			cpu_rdata = rdata.sio;
		end else if (io_sel.tim) begin
			cpu_rdata = rdata.tim;
		end else if (io_sel.snd) begin
			cpu_rdata = rdata.snd;
		end else if (io_sel.ppu) begin
			cpu_rdata = rdata.ppu;
		end else if (io_sel.iflag || io_sel.iena) begin
			cpu_rdata = rdata.ireg;
		end else if (cpu_sel.brom) begin
			// No boot image here; low address byte stands in.
			cpu_rdata = cpu_adr.io.reg_ofs;
		end else if (cpu_grant_vram) begin
			cpu_rdata = rdata.vram;
		end else if (cpu_grant_oam) begin
			cpu_rdata = rdata.oam;
		end else if (cpu_grant_ext) begin
			cpu_rdata = rdata.ext;
		end
	end

	always_comb begin
		dma_rdata = 8'hff;

		if (dma_grant_vram) begin
			dma_rdata = rdata.vram;
		end else if (dma_grant_ext) begin
			dma_rdata = rdata.ext;
		end
	end

endmodule

// File: hdl/gb_ext_port.sv
`timescale 1ns/1ps

module gb_ext_port (
	input  logic                  gbclk,
	input  logic                  reset,
	input  logic                  reset_done,
	input  gb_bus_pkg::bus_req_t  ext_req,
	input  logic                  cs_rom,
	input  logic                  cs_xram,
	input  logic                  cs_wram,
	output gb_bus_pkg::ext_pins_t pins
);

	logic [15:0] adr_q;
	logic [7:0]  data_q;
	logic        n_read_q;
	logic        n_write_q;
	logic        n_cs_rom_q;
	logic        n_cs_xram_q;
	logic        n_cs_wram_q;
	logic        wr_q;
	logic        oe_q;

	always_ff @(posedge gbclk) begin
		adr_q  <= ext_req.adr.mem;
		data_q <= ext_req.wdata;
	end

	always_ff @(posedge gbclk) begin
		if (reset) begin
			n_read_q    <= 1'b1;
			n_write_q   <= 1'b1;
			n_cs_rom_q  <= 1'b1;
			n_cs_xram_q <= 1'b1;
			n_cs_wram_q <= 1'b1;
			wr_q        <= 1'b0;
			oe_q        <= 1'b0;
		end else begin
			n_read_q    <= !ext_req.rd;
			n_write_q   <= !ext_req.wr;
			n_cs_rom_q  <= !(reset_done && cs_rom);
			n_cs_xram_q <= !(reset_done && cs_xram);
			n_cs_wram_q <= !cs_wram;
			wr_q        <= ext_req.wr;
			// Hold the data drivers one cycle past the write.
			oe_q        <= ext_req.wr || wr_q;
		end
	end

	always_comb begin
		pins.adr       = adr_q;
		pins.n_read    = n_read_q;
		pins.n_write   = n_write_q;
		pins.data_oe   = oe_q && reset_done;
		pins.data_out  = data_q;
		pins.n_cs_rom  = n_cs_rom_q;
		pins.n_cs_xram = n_cs_xram_q;
		pins.n_cs_wram = n_cs_wram_q;
	end

endmodule

// File: hdl/gb_bus_top.sv
`timescale 1ns/1ps

module gb_bus_top (
	input  logic                      gbclk,
	input  logic                      reset,
	input  logic                      gb_on,
	input  logic                      cart_rst_n,
	input  gb_bus_pkg::bus_req_t      cpu_req,
	input  gb_bus_pkg::dma_req_t      dma_req,
	input  gb_bus_pkg::ppu_req_t      ppu_req,
	input  gb_bus_pkg::periph_rdata_t periph_rdata,
	output logic [7:0]                cpu_rdata,
	output logic [7:0]                dma_rdata,
	output gb_bus_pkg::mem_port_t     vram_port,
	output gb_bus_pkg::mem_port_t     oam_port,
	output gb_bus_pkg::io_sel_t       io_sel,
	output gb_bus_pkg::ext_pins_t     ext_pins,
	output logic                      reset_done,
	output logic                      bus_reset,
	output logic                      cart_rst_drive_n,
	output logic                      boot_hidden
);

	import gb_bus_pkg::*;

	mem_sel_t cpu_sel;
	mem_sel_t dma_sel;
	mem_sel_t ppu_sel;
	bus_req_t ext_req;
	logic     cs_rom;
	logic     cs_xram;
	logic     cs_wram;
	logic     cpu_grant_vram;
	logic     cpu_grant_oam;
	logic     cpu_grant_ext;
	logic     dma_grant_vram;
	logic     dma_grant_ext;

	gb_memmap cpu_map (
		.adr(cpu_req.adr.mem), .boot_en(!boot_hidden), .idle(1'b0), .sel(cpu_sel)
	);

	gb_memmap dma_map (
		.adr(dma_req.rd_adr), .boot_en(1'b0), .idle(!dma_req.active), .sel(dma_sel)
	);

	gb_memmap ppu_map (
		.adr(ppu_req.adr), .boot_en(1'b0), .idle(1'b0), .sel(ppu_sel)
	);

	gb_io_decode io_map (
		.gbclk(gbclk), .reset(reset), .bus_reset(bus_reset), .cpu_adr(cpu_req.adr),
		.io_page(cpu_sel.io), .wr(cpu_req.wr), .wdata(cpu_req.wdata),
		.sel(io_sel), .boot_hidden(boot_hidden)
	);

	gb_reset_seq rst_seq (
		.gbclk(gbclk), .reset(reset), .gb_on(gb_on), .cart_rst_n(cart_rst_n),
		.reset_done(reset_done), .bus_reset(bus_reset), .cart_rst_drive_n(cart_rst_drive_n)
	);

	gb_bus_arbiter arb (
		.cpu_req(cpu_req), .dma_req(dma_req), .ppu_req(ppu_req),
		.cpu_sel(cpu_sel), .dma_sel(dma_sel), .ppu_sel(ppu_sel),
		.vram_port(vram_port), .oam_port(oam_port), .ext_req(ext_req),
		.cs_rom(cs_rom), .cs_xram(cs_xram), .cs_wram(cs_wram),
		.cpu_grant_vram(cpu_grant_vram), .cpu_grant_oam(cpu_grant_oam),
		.cpu_grant_ext(cpu_grant_ext), .dma_grant_vram(dma_grant_vram),
		.dma_grant_ext(dma_grant_ext)
	);

	gb_read_mux rd_mux (
		.io_sel(io_sel), .cpu_sel(cpu_sel), .cpu_adr(cpu_req.adr),
		.grants({cpu_grant_vram, cpu_grant_oam, cpu_grant_ext,
			dma_grant_vram, dma_grant_ext}),
		.rdata(periph_rdata), .cpu_rdata(cpu_rdata), .dma_rdata(dma_rdata)
	);

	gb_ext_port ext_port (
		.gbclk(gbclk), .reset(reset), .reset_done(reset_done), .ext_req(ext_req),
		.cs_rom(cs_rom), .cs_xram(cs_xram), .cs_wram(cs_wram), .pins(ext_pins)
	);

endmodule

// File: bench/tb_gb_bus.sv
`timescale 1ns/1ps

module tb_gb_bus;

	import gb_bus_pkg::*;

	localparam int R_NONE = 0;
	localparam int R_BROM = 1;
	localparam int R_ROM  = 2;
	localparam int R_VRAM = 3;
	localparam int R_XRAM = 4;
	localparam int R_WRAM = 5;
	localparam int R_OAM  = 6;
	localparam int R_IO   = 7;

	logic          gbclk;
	logic          reset;
	logic          gb_on;
	logic          cart_rst_n;
	bus_req_t      cpu_req;
	dma_req_t      dma_req;
	ppu_req_t      ppu_req;
	periph_rdata_t periph_rdata;
	logic [7:0]    cpu_rdata;
	logic [7:0]    dma_rdata;
	mem_port_t     vram_port;
	mem_port_t     oam_port;
	io_sel_t       io_sel;
	ext_pins_t     ext_pins;
	logic          reset_done;
	logic          bus_reset;
	logic          cart_rst_drive_n;
	logic          boot_hidden;

	logic [31:0]   lfsr;
	int            n_checks;
	int            n_errors;
	logic          timed_out;
	logic          cmp_on;
	logic          hid_model;
	logic          pins_valid;
	logic          last_wr;
	ext_pins_t     exp_pins;
	ext_pins_t     pins_next;

	gb_bus_top DUT (
		.gbclk(gbclk), .reset(reset), .gb_on(gb_on), .cart_rst_n(cart_rst_n),
		.cpu_req(cpu_req), .dma_req(dma_req), .ppu_req(ppu_req),
		.periph_rdata(periph_rdata), .cpu_rdata(cpu_rdata), .dma_rdata(dma_rdata),
		.vram_port(vram_port), .oam_port(oam_port), .io_sel(io_sel),
		.ext_pins(ext_pins), .reset_done(reset_done), .bus_reset(bus_reset),
		.cart_rst_drive_n(cart_rst_drive_n), .boot_hidden(boot_hidden)
	);

	initial begin
		gbclk = 1'b0;
		forever #5 gbclk = ~gbclk;
	end

	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v = {v[6:0], rand_bit()};
		end
		return v;
	endfunction

	// Biased toward the regions with arbitration.
	function automatic logic [15:0] rand_adr();
		logic [2:0]  kind;
		logic [15:0] a;
		kind = {rand_bit(), rand_bit(), rand_bit()};
		a = {rand_byte(), rand_byte()};
		case (kind)
			3'd1: a[15:8] = 8'hff;
			3'd2: a[15:8] = 8'h00;
			3'd3: a[15:13] = 3'b100;
			3'd4: a[15:8] = 8'hfe;
			3'd5: a[15:13] = 3'b101;
			3'd6: a[15:14] = 2'b11;
			default: begin
			end
		endcase
		return a;
	endfunction

	function automatic int region_of(input logic [15:0] a, input logic boot);
		if (boot && a < 16'h0100) return R_BROM;
		if (a < 16'h8000) return R_ROM;
		if (a < 16'ha000) return R_VRAM;
		if (a < 16'hc000) return R_XRAM;
		// Echo RAM lands on work RAM.
		if (a < 16'hfe00) return R_WRAM;
		if (a < 16'hfea0) return R_OAM;
		if (a >= 16'hff00) return R_IO;
		return R_NONE;
	endfunction

	function automatic logic is_ext(input int r);
		return r == R_ROM || r == R_XRAM || r == R_WRAM;
	endfunction

	function automatic int dma_region(input dma_req_t d);
		return d.active ? region_of(d.rd_adr, 1'b0) : R_NONE;
	endfunction

	// Register groups of the I/O page.
	function automatic io_sel_t ref_io_sel(input bus_req_t c);
		io_sel_t    s;
		logic [7:0] o;
		s = '0;
		o = c.adr.mem[7:0];
		if (region_of(c.adr.mem, 1'b0) == R_IO) begin
			s.joy   = o == 8'h00;
			s.sio   = o == 8'h01 || o == 8'h02;
			s.tim   = o >= 8'h04 && o <= 8'h07;
			s.iflag = o == 8'h0f;
			s.snd   = o >= 8'h10 && o <= 8'h3f;
			s.ppu   = o >= 8'h40 && o <= 8'h4b;
			s.brom  = o == 8'h50;
			s.hram  = o >= 8'h80 && o != 8'hff;
			s.iena  = o == 8'hff;
		end
		return s;
	endfunction

	function automatic logic [7:0] ref_cpu_rdata(input bus_req_t c, input dma_req_t d,
		input ppu_req_t p, input periph_rdata_t r, input logic hid);
		int         creg;
		logic [7:0] o;
		logic [7:0] v;
		creg = region_of(c.adr.mem, !hid);
		o = c.adr.mem[7:0];
		v = 8'hff;
		if (creg == R_IO) begin
			if (o >= 8'h80 && o != 8'hff) v = r.hram;
			else if (o == 8'h00) v = r.joy;
			else if (o == 8'h01 || o == 8'h02) v = r.sio;
			else if (o >= 8'h04 && o <= 8'h07) v = r.tim;
			else if (o >= 8'h10 && o <= 8'h3f) v = r.snd;
			else if (o >= 8'h40 && o <= 8'h4b) v = r.ppu;
			else if (o == 8'h0f || o == 8'hff) v = r.ireg;
		end else if (creg == R_BROM) begin
			v = o;
		end else if (creg == R_VRAM) begin
			if (!p.need_vram && dma_region(d) != R_VRAM) v = r.vram;
		end else if (creg == R_OAM) begin
			if (!p.need_oam && !d.active) v = r.oam;
		end else if (is_ext(creg) && !is_ext(dma_region(d))) begin
			v = r.ext;
		end
		return v;
	endfunction

	function automatic logic [7:0] ref_dma_rdata(input dma_req_t d, input ppu_req_t p,
		input periph_rdata_t r);
		if (dma_region(d) == R_VRAM && !p.need_vram) return r.vram;
		if (is_ext(dma_region(d))) return r.ext;
		return 8'hff;
	endfunction

	function automatic mem_port_t ref_vram_port(input bus_req_t c, input dma_req_t d,
		input ppu_req_t p);
		mem_port_t m;
		m = '0;
		if (p.need_vram) begin
			m.adr = p.adr;
			m.rd  = p.rd && region_of(p.adr, 1'b0) == R_VRAM;
		end else if (dma_region(d) == R_VRAM) begin
			m.adr = d.rd_adr;
			m.rd  = d.rd;
		end else if (region_of(c.adr.mem, 1'b0) == R_VRAM) begin
			m = {c.adr.mem, c.rd, c.wr, c.wdata};
		end
		return m;
	endfunction

	function automatic mem_port_t ref_oam_port(input bus_req_t c, input dma_req_t d,
		input ppu_req_t p);
		mem_port_t m;
		m = '0;
		if (p.need_oam) begin
			m.adr = p.adr;
			m.rd  = p.rd && region_of(p.adr, 1'b0) == R_OAM;
		end else if (d.active) begin
			m = {8'hfe, d.oam_adr, 1'b0, d.wr, d.wdata};
		end else if (region_of(c.adr.mem, 1'b0) == R_OAM) begin
			m = {c.adr.mem, c.rd, c.wr, c.wdata};
		end
		return m;
	endfunction

	// Pins as seen after the next edge, with the bus already out of reset.
	function automatic ext_pins_t ref_ext_pins(input bus_req_t c, input dma_req_t d,
		input logic hid, input logic prev_wr);
		ext_pins_t e;
		int        creg;
		int        dreg;
		logic      dext;
		creg = region_of(c.adr.mem, !hid);
		dreg = dma_region(d);
		dext = is_ext(dreg);
		e.adr       = dext ? d.rd_adr : c.adr.mem;
		e.n_read    = dext ? !d.rd : !c.rd;
		e.n_write   = dext ? 1'b1 : !c.wr;
		e.data_oe   = !e.n_write || prev_wr;
		e.data_out  = c.wdata;
		e.n_cs_rom  = !(creg == R_ROM || dreg == R_ROM);
		e.n_cs_xram = !(creg == R_XRAM || dreg == R_XRAM);
		e.n_cs_wram = !(creg == R_WRAM || dreg == R_WRAM);
		return e;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	always @(posedge gbclk) begin
		pins_next = ref_ext_pins(cpu_req, dma_req, hid_model, last_wr);
		exp_pins   <= pins_next;
		last_wr    <= !pins_next.n_write;
		pins_valid <= cmp_on;
	end

	always @(negedge gbclk) begin
		if (cmp_on) begin
			check("cpu_rdata", cpu_rdata,
				ref_cpu_rdata(cpu_req, dma_req, ppu_req, periph_rdata, hid_model));
			check("dma_rdata", dma_rdata, ref_dma_rdata(dma_req, ppu_req, periph_rdata));
			check("vram_port", vram_port, ref_vram_port(cpu_req, dma_req, ppu_req));
			check("oam_port", oam_port, ref_oam_port(cpu_req, dma_req, ppu_req));
			check("io_sel", io_sel, ref_io_sel(cpu_req));
			check("boot_hidden", boot_hidden, hid_model);
			if (pins_valid) begin
				check("ext_pins", ext_pins, exp_pins);
			end
		end
	end

	task automatic drive_random();
		@(posedge gbclk);
		#1;
		cpu_req.adr.mem = rand_adr();
		cpu_req.rd      = rand_bit();
		cpu_req.wr      = rand_bit();
		cpu_req.wdata   = rand_byte();
		// Boot register writes belong to the directed part.
		if (cpu_req.adr.mem == 16'hff50) cpu_req.wr = 1'b0;
		dma_req = {rand_bit(), rand_adr(), rand_byte(), rand_bit(), rand_bit(), rand_byte()};
		ppu_req = {rand_adr(), rand_bit(), rand_bit(), rand_bit()};
		for (int i = 0; i < 10; i++) begin
			periph_rdata[i*8 +: 8] = rand_byte();
		end
	endtask

	task automatic step_cpu(input logic [15:0] a, input logic rd, input logic wr,
		input logic [7:0] d);
		@(posedge gbclk);
		#1;
		cpu_req = {a, rd, wr, d};
		dma_req = '0;
		ppu_req = '0;
	endtask

	// Counts edges until reset_done, checking the drive window and bus reset each cycle.
	task automatic measure_sequence(input string what, input int lo, input int hi,
		input int done_at, input int cart_from, input int cart_len);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n <= done_at + 32) begin
			@(negedge gbclk);
			check("cart_rst_drive_n", cart_rst_drive_n, (n >= lo && n < hi) ? 0 : 1);
			check("reset_done", reset_done, n >= done_at);
			check("bus_reset", bus_reset, !(n >= done_at && gb_on));
			seen = reset_done;
			if (!seen) begin
				@(posedge gbclk);
				n++;
				#1;
				cart_rst_n = !(n >= cart_from && n < cart_from + cart_len);
			end
		end
		if (!seen) begin
			$display("Timeout: reset_done never rose in the %s sequence", what);
			n_errors++;
			timed_out = 1'b1;
		end else begin
			check({what, " done cycle"}, n, done_at);
		end
	endtask

	initial begin
		lfsr = 32'h4319;
		n_checks = 0;
		n_errors = 0;
		timed_out = 1'b0;
		cmp_on = 1'b0;
		hid_model = 1'b0;
		last_wr = 1'b0;
		reset = 1'b1;
		gb_on = 1'b1;
		cart_rst_n = 1'b1;
		cpu_req = '0;
		dma_req = '0;
		ppu_req = '0;
		periph_rdata = '0;

		repeat (3) @(posedge gbclk);
		#1;
		reset = 1'b0;
		measure_sequence("power-on", 16, 32, 48, 0, 0);

		if (!timed_out) begin
			@(posedge gbclk);
			#1;
			cmp_on = 1'b1;
			repeat (400) drive_random();

			// Boot ROM stays until a nonzero write to the boot register.
			step_cpu(16'h0042, 1'b1, 1'b0, 8'h00);
			step_cpu(16'hff50, 1'b0, 1'b1, 8'h00);
			step_cpu(16'h0042, 1'b1, 1'b0, 8'h00);
			step_cpu(16'hff50, 1'b0, 1'b1, 8'h01);
			step_cpu(16'h0042, 1'b1, 1'b0, 8'h00);
			hid_model = 1'b1;
			step_cpu(16'h00ff, 1'b1, 1'b1, 8'h5a);
			step_cpu(16'h0010, 1'b0, 1'b0, 8'h00);
			repeat (60) drive_random();
			step_cpu(16'h0000, 1'b0, 1'b0, 8'h00);
			cmp_on = 1'b0;

			// A one-cycle low on gb_on; both edges restart the assert phase.
			@(posedge gbclk);
			#1;
			gb_on = 1'b0;
			hid_model = 1'b0;
			@(negedge gbclk);
			check("bus_reset", bus_reset, 1);
			@(posedge gbclk);
			#1;
			gb_on = 1'b1;
			measure_sequence("gb_on restart", 0, 17, 33, 0, 0);
			check("boot_hidden", boot_hidden, 0);

			// Cartridge pulls reset once running, then again during release.
			@(posedge gbclk);
			#1;
			cart_rst_n = 1'b0;
			@(posedge gbclk);
			#1;
			cart_rst_n = 1'b1;
			measure_sequence("cartridge reset", 0, 16, 41, 20, 5);

			@(posedge gbclk);
			#1;
			cmp_on = 1'b1;
			repeat (40) drive_random();
			step_cpu(16'h0000, 1'b0, 1'b0, 8'h00);
			@(negedge gbclk);
			cmp_on = 1'b0;
		end

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
hdl/gb_bus_pkg.sv
hdl/gb_memmap.sv
hdl/gb_io_decode.sv
hdl/gb_reset_seq.sv
hdl/gb_bus_arbiter.sv
hdl/gb_read_mux.sv
hdl/gb_ext_port.sv
hdl/gb_bus_top.sv
bench/tb_gb_bus.sv

// File: run_sim.sh
#!/bin/bash
# Build with Verilator, run, and fail when the log holds the fail message.
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_gb_bus > build.log 2>&1 &&
./obj_dir/Vtb_gb_bus > sim.log 2>&1 &&
! grep -q "TESTS FAILED" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
